// File: all.f
source/axi_rd_pkg.sv
source/axil_rd_if.sv
source/axi_axil_rd.sv
source/axil_rd_decoder.sv
source/axil_rd_rom.sv
source/axil_rd_info.sv
source/axi_rd_bridge_top.sv
sim/axi_rd_bridge_assertions.sv
sim/tb_axi_rd_bridge.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_rd_bridge \
  -f all.f \
  -o tb_axi_rd_bridge \
  && ./obj_dir/tb_axi_rd_bridge \
  || { echo "Simulation did not complete cleanly"; exit 1; }

// File: source/rom_init.hex
// ROM words 0 to 15, one 32-bit hex word per line
1F2E3D40
5B6A7988
0C1D2E3F
9A8B7C6D
11223344
55667788
99AABBCC
DDEEFF00
0F1E2D3C
4B5A6978
8796A5B4
C3D2E1F0
13579BDF
2468ACE0
FEDCBA98
76543210

// File: sim/tb_axi_rd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_bridge;

  localparam int NUM_ENTRIES  = 16;
  localparam int MAX_BEATS    = 17;
  localparam int WATCHDOG_CYC = NUM_ENTRIES * MAX_BEATS * 20 + 200;

  typedef struct packed {
    axi_rd_pkg::id_t   id;
    axi_rd_pkg::addr_t addr;
    axi_rd_pkg::len_t  len;
    axi_rd_pkg::size_t size;
    axi_rd_pkg::resp_t first_resp;
  } entry_t;

  logic                clk;
  logic                rst_n;
  logic                arvalid;
  axi_rd_pkg::id_t     arid;
  axi_rd_pkg::addr_t   araddr;
  axi_rd_pkg::len_t    arlen;
  axi_rd_pkg::size_t   arsize;
  logic [1:0]          arburst;
  logic                arready;
  logic                rvalid;
  axi_rd_pkg::id_t     rid;
  axi_rd_pkg::data_t   rdata;
  axi_rd_pkg::resp_t   rresp;
  logic                rlast;
  logic                rready;

  entry_t              stim [NUM_ENTRIES];
  axi_rd_pkg::data_t   rom_model [axi_rd_pkg::ROM_WORDS];
  axi_rd_pkg::data_t   info_reads;
  logic [31:0]         rng_state;

  axi_rd_bridge_top i_dut (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_arvalid (arvalid),
    .i_arid    (arid),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arsize  (arsize),
    .i_arburst (arburst),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rid     (rid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rlast   (rlast),
    .i_rready  (rready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ID, start address, arlen, arsize, response of the first beat
  task automatic load_table();
    stim[0]  = '{4'd1,  8'h00, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[1]  = '{4'd2,  8'h14, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[2]  = '{4'd3,  8'h3C, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[3]  = '{4'd4,  8'h00, 8'd15, 3'd2, axi_rd_pkg::RESP_OKAY};
    stim[4]  = '{4'd5,  8'h08, 8'd7,  3'd1, axi_rd_pkg::RESP_OKAY};
    stim[5]  = '{4'd6,  8'h40, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[6]  = '{4'd7,  8'h44, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[7]  = '{4'd8,  8'h48, 8'd0,  3'd2, axi_rd_pkg::RESP_SLVERR};
    stim[8]  = '{4'd9,  8'h4C, 8'd0,  3'd2, axi_rd_pkg::RESP_SLVERR};
    stim[9]  = '{4'd10, 8'h44, 8'd0,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[10] = '{4'd11, 8'h50, 8'd0,  3'd2, axi_rd_pkg::RESP_DECERR};
    stim[11] = '{4'd12, 8'hFC, 8'd0,  3'd2, axi_rd_pkg::RESP_DECERR};
    // ROM into info block
    stim[12] = '{4'd13, 8'h38, 8'd5,  3'd2, axi_rd_pkg::RESP_OKAY};
    stim[13] = '{4'd14, 8'h4C, 8'd2,  3'd2, axi_rd_pkg::RESP_SLVERR};
    stim[14] = '{4'd15, 8'h00, 8'd15, 3'd2, axi_rd_pkg::RESP_OKAY};
    stim[15] = '{4'd0,  8'h40, 8'd3,  3'd0, axi_rd_pkg::RESP_OKAY};
  endtask

  // Expected word and response for one beat at a byte address
  task automatic model_beat(input axi_rd_pkg::addr_t addr, output axi_rd_pkg::data_t data,
                            output axi_rd_pkg::resp_t resp);
    axi_rd_pkg::addr_t offset;
    data = '0;
    resp = axi_rd_pkg::RESP_DECERR;
    offset = addr - axi_rd_pkg::INFO_BASE;
    if (int'(addr) < axi_rd_pkg::ROM_WORDS * 4) begin
      data = rom_model[addr[5:2]];
      resp = axi_rd_pkg::RESP_OKAY;
    end else if (int'(offset) < axi_rd_pkg::INFO_WORDS * 4) begin
      case (offset[3:2])
        2'd0: begin
          data = axi_rd_pkg::INFO_VERSION;
          resp = axi_rd_pkg::RESP_OKAY;
        end
        2'd1: begin
          data = info_reads;
          resp = axi_rd_pkg::RESP_OKAY;
        end
        default: resp = axi_rd_pkg::RESP_SLVERR;
      endcase
      info_reads = info_reads + 32'd1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    assert (got_val === exp_val) else begin
      $display("ERROR %s expected %h got %h", name, exp_val, got_val);
      $display("RESULT: FAIL");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic run_burst(input entry_t e);
    int                  beat;
    logic                done;
    axi_rd_pkg::addr_t   beat_addr;
    axi_rd_pkg::data_t   exp_data;
    axi_rd_pkg::resp_t   exp_resp;

    @(posedge clk);
    arvalid <= 1'b1;
    arid    <= e.id;
    araddr  <= e.addr;
    arlen   <= e.len;
    arsize  <= e.size;
    arburst <= 2'b01;
    done = 1'b0;
    // Handshake lands on the edge after a negedge with arready high
    while (!done) begin
      @(negedge clk);
      done = arready;
      @(posedge clk);
    end
    arvalid <= 1'b0;

    beat = 0;
    beat_addr = e.addr;
    done = 1'b0;
    while (!done) begin
      rng_state = xorshift32(rng_state);
      rready <= (rng_state % 32'd10) < 32'd7;
      @(negedge clk);
      if (rvalid && rready) begin
        model_beat(beat_addr, exp_data, exp_resp);
        check_value("rid", 32'(e.id), 32'(rid));
        check_value("rdata", exp_data, rdata);
        check_value("rresp", 32'(exp_resp), 32'(rresp));
        check_value("rlast", 32'(beat == int'(e.len)), 32'(rlast));
        if (beat == 0) begin
          check_value("rresp", 32'(e.first_resp), 32'(rresp));
        end
        done = rlast;
        beat++;
        beat_addr = beat_addr + (axi_rd_pkg::addr_t'(1) << e.size);
      end
      @(posedge clk);
    end
    rready <= 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    arvalid    = 1'b0;
    arid       = '0;
    araddr     = '0;
    arlen      = '0;
    arsize     = '0;
    arburst    = '0;
    rready     = 1'b0;
    rng_state  = 32'd45;
    info_reads = '0;
    $readmemh("source/rom_init.hex", rom_model);
    load_table();

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_burst(stim[i]);
    end
    repeat (2) @(posedge clk);

    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Run timed out after %0d cycles before the table was done", WATCHDOG_CYC);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: sim/axi_rd_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_bridge_assertions (
  input wire logic                i_clk,
  input wire logic                i_rst_n,
  input wire logic                i_arready,
  input wire logic                i_rvalid,
  input wire axi_rd_pkg::id_t     i_rid,
  input wire axi_rd_pkg::data_t   i_rdata,
  input wire axi_rd_pkg::resp_t   i_rresp,
  input wire logic                i_rlast,
  input wire logic                i_rready
);

  // First cycle out of reset
  assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_arready && !i_rvalid)
    else $error("arready or rvalid high in the first cycle after reset");

  // R beat and payload hold while stalled
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp)
                              && $stable(i_rid) && $stable(i_rlast))
    else $error("R channel changed while rready was low");

  // rlast only together with a beat
  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_rlast |-> i_rvalid)
    else $error("rlast high without rvalid");

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rvalid && i_rready && i_rlast |=> i_arready)
    else $error("arready did not return after the last beat");

endmodule

bind axi_rd_bridge_top axi_rd_bridge_assertions u_assertions (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .i_arready (o_arready),
  .i_rvalid  (o_rvalid),
  .i_rid     (o_rid),
  .i_rdata   (o_rdata),
  .i_rresp   (o_rresp),
  .i_rlast   (o_rlast),
  .i_rready  (i_rready)
);

`default_nettype wire

// File: source/axi_rd_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_bridge_top (
  input  logic                i_clk,
  input  logic                i_rst_n,

  input  logic                i_arvalid,
  input  axi_rd_pkg::id_t     i_arid,
  input  axi_rd_pkg::addr_t   i_araddr,
  input  axi_rd_pkg::len_t    i_arlen,
  input  axi_rd_pkg::size_t   i_arsize,
  input  logic [1:0]          i_arburst,
  output logic                o_arready,

  output logic                o_rvalid,
  output axi_rd_pkg::id_t     o_rid,
  output axi_rd_pkg::data_t   o_rdata,
  output axi_rd_pkg::resp_t   o_rresp,
  output logic                o_rlast,
  input  logic                i_rready
);

  axil_rd_if m_axil ();
  axil_rd_if rom_axil ();
  axil_rd_if info_axil ();

  axi_axil_rd u_adapter (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_arvalid (i_arvalid),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arsize  (i_arsize),
    .i_arburst (i_arburst),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .o_rid     (o_rid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rlast   (o_rlast),
    .i_rready  (i_rready),
    .m_axil    (m_axil.mgr)
  );

  axil_rd_decoder u_decoder (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .up      (m_axil.sub),
    .rom     (rom_axil.mgr),
    .info    (info_axil.mgr)
  );

  axil_rd_rom u_rom (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .s       (rom_axil.sub)
  );

  axil_rd_info u_info (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .s       (info_axil.sub)
  );

endmodule

`default_nettype wire

// File: source/axil_rd_info.sv
`timescale 1ns/1ps
`default_nettype none

module axil_rd_info (
  input  logic    i_clk,
  input  logic    i_rst_n,
  axil_rd_if.sub  s
);

  localparam int IDX_W = $clog2(axi_rd_pkg::INFO_WORDS);

  axi_rd_pkg::data_t   read_count;
  logic [IDX_W-1:0]    reg_idx;

  assign reg_idx   = s.araddr[2 +: IDX_W];
  assign s.arready = !s.rvalid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s.rvalid   <= 1'b0;
      read_count <= '0;
    end else if (s.arvalid && s.arready) begin
      s.rvalid <= 1'b1;
    end else if (s.rvalid && s.rready) begin
      s.rvalid   <= 1'b0;
      // Counts error reads too
      read_count <= read_count + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s.arvalid && s.arready) begin
      case (reg_idx)
        2'd0: begin
          s.rdata <= axi_rd_pkg::INFO_VERSION;
          s.rresp <= axi_rd_pkg::RESP_OKAY;
        end
        2'd1: begin
          s.rdata <= read_count;
          s.rresp <= axi_rd_pkg::RESP_OKAY;
        end
        default: begin
          s.rdata <= '0;
          s.rresp <= axi_rd_pkg::RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/axil_rd_rom.sv
`timescale 1ns/1ps
`default_nettype none

module axil_rd_rom (
  input  logic    i_clk,
  input  logic    i_rst_n,
  axil_rd_if.sub  s
);

  localparam int IDX_W = $clog2(axi_rd_pkg::ROM_WORDS);

  axi_rd_pkg::data_t   mem [axi_rd_pkg::ROM_WORDS];
  logic [IDX_W-1:0]    word_idx;

  initial begin
    $readmemh("source/rom_init.hex", mem);
  end

  // Byte lanes within a word are ignored
  assign word_idx = s.araddr[2 +: IDX_W];

  assign s.arready = !s.rvalid;
  assign s.rresp   = axi_rd_pkg::RESP_OKAY;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s.rvalid <= 1'b0;
    end else if (s.arvalid && s.arready) begin
      s.rvalid <= 1'b1;
    end else if (s.rvalid && s.rready) begin
      s.rvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s.arvalid && s.arready) begin
      s.rdata <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// File: source/axil_rd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module axil_rd_decoder (
  input  logic    i_clk,
  input  logic    i_rst_n,
  axil_rd_if.sub  up,
  axil_rd_if.mgr  rom,
  axil_rd_if.mgr  info
);

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_ROM,
    DEC_INFO,
    DEC_ERR
  } dec_state_t;

  dec_state_t          state;
  axi_rd_pkg::addr_t   rom_off;
  axi_rd_pkg::addr_t   info_off;
  logic                hit_rom;
  logic                hit_info;

  // Offsets wrap for addresses below a base, so one compare per region
  assign rom_off  = up.araddr - axi_rd_pkg::ROM_BASE;
  assign info_off = up.araddr - axi_rd_pkg::INFO_BASE;
  assign hit_rom  = rom_off < axi_rd_pkg::addr_t'(axi_rd_pkg::ROM_WORDS * 4);
  assign hit_info = info_off < axi_rd_pkg::addr_t'(axi_rd_pkg::INFO_WORDS * 4);

  assign rom.araddr   = rom_off;
  assign info.araddr  = info_off;
  assign rom.arvalid  = up.arvalid && (state == DEC_IDLE) && hit_rom;
  assign info.arvalid = up.arvalid && (state == DEC_IDLE) && hit_info;

  always_comb begin
    up.arready = 1'b0;
    up.rvalid  = 1'b0;
    up.rdata   = '0;
    up.rresp   = axi_rd_pkg::RESP_OKAY;
    rom.rready  = 1'b0;
    info.rready = 1'b0;

    case (state)
      DEC_IDLE: begin
        if (hit_rom) begin
          up.arready = rom.arready;
        end else if (hit_info) begin
          up.arready = info.arready;
        end else begin
          up.arready = 1'b1;
        end
      end
      DEC_ROM: begin
        up.rvalid  = rom.rvalid;
        up.rdata   = rom.rdata;
        up.rresp   = rom.rresp;
        rom.rready = up.rready;
      end
      DEC_INFO: begin
        up.rvalid   = info.rvalid;
        up.rdata    = info.rdata;
        up.rresp    = info.rresp;
        info.rready = up.rready;
      end
      default: begin
        // Unmapped address answered here
        up.rvalid = 1'b1;
        up.rresp  = axi_rd_pkg::RESP_DECERR;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= DEC_IDLE;
    end else begin
      case (state)
        DEC_IDLE: begin
          if (up.arvalid && up.arready) begin
            state <= hit_rom ? DEC_ROM : (hit_info ? DEC_INFO : DEC_ERR);
          end
        end
        default: begin
          if (up.rvalid && up.rready) begin
            state <= DEC_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/axi_axil_rd.sv
`timescale 1ns/1ps
`default_nettype none

module axi_axil_rd (
  input  logic                i_clk,
  input  logic                i_rst_n,

  input  logic                i_arvalid,
  input  axi_rd_pkg::id_t     i_arid,
  input  axi_rd_pkg::addr_t   i_araddr,
  input  axi_rd_pkg::len_t    i_arlen,
  input  axi_rd_pkg::size_t   i_arsize,
  // Burst type ignored and every burst runs as INCR
  input  logic [1:0]          i_arburst,
  output logic                o_arready,

  output logic                o_rvalid,
  output axi_rd_pkg::id_t     o_rid,
  output axi_rd_pkg::data_t   o_rdata,
  output axi_rd_pkg::resp_t   o_rresp,
  output logic                o_rlast,
  input  logic                i_rready,

  axil_rd_if.mgr              m_axil
);

  typedef enum logic {
    ST_IDLE,
    ST_BURST
  } state_t;

  state_t              state;
  state_t              state_next;

  axi_rd_pkg::addr_t   r_addr;
  axi_rd_pkg::addr_t   addr_next;
  axi_rd_pkg::id_t     r_id;
  axi_rd_pkg::id_t     id_next;
  axi_rd_pkg::len_t    r_len;
  axi_rd_pkg::len_t    len_next;
  axi_rd_pkg::size_t   r_size;
  axi_rd_pkg::size_t   size_next;
  axi_rd_pkg::addr_t   beat_bytes;

  logic                arready_next;
  logic                last_q;
  logic                rlast_next;
  logic                m_arvalid_next;
  axi_rd_pkg::addr_t   m_araddr_next;

  // Beats pass straight through, tagged with the stored ID
  assign o_rvalid      = m_axil.rvalid;
  assign o_rdata       = m_axil.rdata;
  assign o_rresp       = m_axil.rresp;
  assign o_rid         = r_id;
  assign m_axil.rready = i_rready;

  // Registered last flag shown only with a beat
  assign o_rlast = last_q && m_axil.rvalid;

  assign beat_bytes = axi_rd_pkg::addr_t'(1) << r_size;

  always_comb begin
    state_next     = state;
    addr_next      = r_addr;
    id_next        = r_id;
    len_next       = r_len;
    size_next      = r_size;
    arready_next   = 1'b0;
    rlast_next     = last_q;
    m_arvalid_next = m_axil.arvalid && !m_axil.arready;
    m_araddr_next  = m_axil.araddr;

    case (state)
      ST_IDLE: begin
        arready_next = 1'b1;
        if (i_arvalid && o_arready) begin
          state_next     = ST_BURST;
          arready_next   = 1'b0;
          addr_next      = i_araddr;
          id_next        = i_arid;
          len_next       = i_arlen;
          size_next      = i_arsize;
          m_arvalid_next = 1'b1;
          m_araddr_next  = i_araddr;
          rlast_next     = (i_arlen == '0);
        end
      end

      ST_BURST: begin
        if (m_axil.rvalid && m_axil.rready) begin
          addr_next  = r_addr + beat_bytes;
          len_next   = r_len - 1'b1;
          rlast_next = (len_next == '0);
          if (r_len == '0) begin
            state_next     = ST_IDLE;
            arready_next   = 1'b1;
            m_arvalid_next = 1'b0;
          end else begin
            // Next single read of the burst
            m_arvalid_next = 1'b1;
            m_araddr_next  = addr_next;
          end
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state          <= ST_IDLE;
      o_arready      <= 1'b0;
      last_q         <= 1'b0;
      m_axil.arvalid <= 1'b0;
    end else begin
      state          <= state_next;
      o_arready      <= arready_next;
      last_q         <= rlast_next;
      m_axil.arvalid <= m_arvalid_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_addr        <= addr_next;
    r_id          <= id_next;
    r_len         <= len_next;
    r_size        <= size_next;
    m_axil.araddr <= m_araddr_next;
  end

endmodule

`default_nettype wire

// File: source/axil_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axil_rd_if;

  logic                arvalid;
  axi_rd_pkg::addr_t   araddr;
  logic                arready;

  logic                rvalid;
  axi_rd_pkg::data_t   rdata;
  axi_rd_pkg::resp_t   rresp;
  logic                rready;

  modport mgr (
    output arvalid,
    output araddr,
    input  arready,
    input  rvalid,
    input  rdata,
    input  rresp,
    output rready
  );

  modport sub (
    input  arvalid,
    input  araddr,
    output arready,
    output rvalid,
    output rdata,
    output rresp,
    input  rready
  );

endinterface

`default_nettype wire

// File: source/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [  ID_WIDTH-1:0] id_t;
  typedef logic [           7:0] len_t;
  typedef logic [           2:0] size_t;
  typedef logic [           1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // Address map, byte addresses
  localparam addr_t ROM_BASE   = 8'h00;
  localparam int    ROM_WORDS  = 16;
  localparam addr_t INFO_BASE  = 8'h40;
  localparam int    INFO_WORDS = 4;

  localparam data_t INFO_VERSION = 32'h0A1D_0001;

endpackage

`default_nettype wire
